//--- Makefile
# Verilator build and run for the machine CSR block

VERILATOR ?= verilator
TOP       ?= csr_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- csr_checker.sv
`timescale 1ns/100ps
`default_nettype none

module csr_checker (
  input  wire logic                        clk_i,
  input  wire logic                        rst_i,
  // DUT inputs
  input  wire riscv_csr_pkg::csr_op_t      csr_op_i,
  input  wire riscv_csr_pkg::csr_addr_t    csr_addr_i,
  input  wire logic [31:0]                 csr_wdata_i,
  input  wire logic                        exc_req_i,
  input  wire logic [31:0]                 exc_cause_i,
  input  wire logic [31:0]                 tval_i,
  input  wire logic [31:0]                 pc_i,
  input  wire logic                        mret_i,
  input  wire logic                        tmr_we_i,
  input  wire riscv_csr_pkg::timer_addr_t  tmr_addr_i,
  input  wire logic [31:0]                 tmr_wdata_i,
  // DUT outputs
  input  wire logic [31:0]                 csr_rdata_i,
  input  wire logic                        trap_i,
  input  wire logic [31:0]                 trap_pc_i,
  input  wire logic [31:0]                 mepc_i,
  input  wire logic [31:0]                 tmr_rdata_i,
  // Totals
  output      int                          err_count_o,
  output      int                          check_count_o
);

  localparam int settle_ns = 4;   // 1 ns ahead of the rising edge
  localparam int mie_b     = riscv_csr_pkg::MSTATUS_MIE_BIT;
  localparam int mpie_b    = riscv_csr_pkg::MSTATUS_MPIE_BIT;
  localparam int mtie_b    = riscv_csr_pkg::MTIE_BIT;
  localparam logic [31:0] mstatus_keep = (32'd1 << mie_b) | (32'd1 << mpie_b);

  // Reference state
  logic [31:0] m_mstatus;
  logic [31:0] m_mie;
  logic [31:0] m_mtvec;
  logic [31:0] m_mscratch;
  logic [31:0] m_mepc;
  logic [31:0] m_mcause;
  logic [31:0] m_mtval;
  logic [63:0] m_mtime;
  logic [63:0] m_mtimecmp;
  int          errors = 0;
  int          checks = 0;

  assign err_count_o   = errors;
  assign check_count_o = checks;

  ////////////////////////////////////////
  // Model helpers
  ////////////////////////////////////////

  task automatic reset_model();
    m_mstatus  = '0;
    m_mie      = '0;
    m_mtvec    = '0;
    m_mscratch = '0;
    m_mepc     = '0;
    m_mcause   = '0;
    m_mtval    = '0;
    m_mtime    = '0;
    m_mtimecmp = '0;
  endtask

  function automatic logic [31:0] csr_value(input logic [11:0] addr, input logic pending);
    logic [31:0] mip_val;
    mip_val = '0;
    mip_val[riscv_csr_pkg::MTIP_BIT] = pending;    // Only MTIP is live
    case (addr)
      riscv_csr_pkg::CSR_MSTATUS:  csr_value = m_mstatus | 32'h0000_1800;  // MPP = 11
      riscv_csr_pkg::CSR_MIE:      csr_value = m_mie;
      riscv_csr_pkg::CSR_MTVEC:    csr_value = m_mtvec;
      riscv_csr_pkg::CSR_MSCRATCH: csr_value = m_mscratch;
      riscv_csr_pkg::CSR_MEPC:     csr_value = m_mepc;
      riscv_csr_pkg::CSR_MCAUSE:   csr_value = m_mcause;
      riscv_csr_pkg::CSR_MTVAL:    csr_value = m_mtval;
      riscv_csr_pkg::CSR_MIP:      csr_value = mip_val;
      default:                     csr_value = '0;
    endcase
  endfunction

  function automatic string csr_name(input logic [11:0] addr);
    case (addr)
      riscv_csr_pkg::CSR_MSTATUS:  csr_name = "mstatus";
      riscv_csr_pkg::CSR_MIE:      csr_name = "mie";
      riscv_csr_pkg::CSR_MTVEC:    csr_name = "mtvec";
      riscv_csr_pkg::CSR_MSCRATCH: csr_name = "mscratch";
      riscv_csr_pkg::CSR_MEPC:     csr_name = "mepc";
      riscv_csr_pkg::CSR_MCAUSE:   csr_name = "mcause";
      riscv_csr_pkg::CSR_MTVAL:    csr_name = "mtval";
      riscv_csr_pkg::CSR_MIP:      csr_name = "mip";
      default:                     csr_name = "unknown csr";
    endcase
  endfunction

  task automatic write_csr(input logic [11:0] addr, input logic [31:0] val);
    case (addr)
      riscv_csr_pkg::CSR_MSTATUS:  m_mstatus  = val & mstatus_keep;
      riscv_csr_pkg::CSR_MIE:      m_mie      = val & (32'd1 << mtie_b);
      riscv_csr_pkg::CSR_MTVEC:    m_mtvec    = val & ~32'd3;
      riscv_csr_pkg::CSR_MSCRATCH: m_mscratch = val;
      riscv_csr_pkg::CSR_MEPC:     m_mepc     = val & ~32'd3;
      riscv_csr_pkg::CSR_MCAUSE:   m_mcause   = val;
      riscv_csr_pkg::CSR_MTVAL:    m_mtval    = val;
      default: ;                                   // mip, unknown
    endcase
  endtask

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s got %08h, expected %08h", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Compare, then advance one edge
  ////////////////////////////////////////

  task automatic step_model();
    logic        pending;
    logic        timer_irq;
    logic        take;
    logic        old_mie;
    logic        old_mpie;
    logic [31:0] old_val;
    logic [31:0] new_val;
    logic [31:0] tmr_exp;
    pending   = (m_mtime >= m_mtimecmp);
    old_mie   = m_mstatus[mie_b];
    old_mpie  = m_mstatus[mpie_b];
    timer_irq = old_mie && m_mie[mtie_b] && pending;
    take      = timer_irq || (old_mie && exc_req_i);
    old_val   = csr_value(csr_addr_i, pending);
    case (tmr_addr_i)
      riscv_csr_pkg::MTIME_LO:    tmr_exp = m_mtime[31:0];
      riscv_csr_pkg::MTIME_HI:    tmr_exp = m_mtime[63:32];
      riscv_csr_pkg::MTIMECMP_LO: tmr_exp = m_mtimecmp[31:0];
      default:                    tmr_exp = m_mtimecmp[63:32];
    endcase
    compare_word(csr_name(csr_addr_i), csr_rdata_i, old_val);   // Old value same cycle
    compare_word("trap", {31'd0, trap_i}, {31'd0, take});
    compare_word("trap_pc", trap_pc_i, m_mtvec);
    compare_word("mepc", mepc_i, m_mepc);
    compare_word("timer word", tmr_rdata_i, tmr_exp);

    if (csr_op_i != riscv_csr_pkg::CSR_NOP) begin
      case (csr_op_i)
        riscv_csr_pkg::CSR_RW: new_val = csr_wdata_i;
        riscv_csr_pkg::CSR_RS: new_val = old_val | csr_wdata_i;
        default:               new_val = old_val & ~csr_wdata_i;
      endcase
      write_csr(csr_addr_i, new_val);
    end
    if (mret_i && !take) begin                     // Suppressed in a trap cycle
      m_mstatus[mie_b]  = old_mpie;
      m_mstatus[mpie_b] = 1'b1;
    end
    if (take) begin                                // Overrides the CSR write
      m_mepc            = {pc_i[31:2], 2'b00};
      m_mcause          = timer_irq ? 32'h8000_0007 : exc_cause_i;
      m_mtval           = timer_irq ? 32'd0 : tval_i;
      m_mstatus[mpie_b] = old_mie;
      m_mstatus[mie_b]  = 1'b0;
    end

    // Timer: a half write replaces that word and skips the count
    if (tmr_we_i && tmr_addr_i == riscv_csr_pkg::MTIME_LO) begin
      m_mtime[31:0] = tmr_wdata_i;
    end else if (tmr_we_i && tmr_addr_i == riscv_csr_pkg::MTIME_HI) begin
      m_mtime[63:32] = tmr_wdata_i;
    end else begin
      m_mtime = m_mtime + 64'd1;
    end
    if (tmr_we_i && tmr_addr_i == riscv_csr_pkg::MTIMECMP_LO) begin
      m_mtimecmp[31:0] = tmr_wdata_i;
    end
    if (tmr_we_i && tmr_addr_i == riscv_csr_pkg::MTIMECMP_HI) begin
      m_mtimecmp[63:32] = tmr_wdata_i;
    end
  endtask

  // Inputs settle after the falling edge, outputs are steady here
  initial begin
    reset_model();
    forever begin
      @(negedge clk_i);
      #(settle_ns);
      if (rst_i) begin
        reset_model();
      end else begin
        step_model();
      end
    end
  end

endmodule

`default_nettype wire

//--- csr_file.sv
`timescale 1ns/100ps
`default_nettype none

module csr_file (
  input  wire logic                            clk,
  input  wire logic                            rst,
  // CSR instruction
  input  wire riscv_csr_pkg::csr_op_t          csr_op_i,
  input  wire riscv_csr_pkg::csr_addr_t        csr_addr_i,
  input  wire logic [riscv_csr_pkg::xlen-1:0]  csr_wdata_i,
  output      logic [riscv_csr_pkg::xlen-1:0]  csr_rdata_o,   // Old value
  // Timer level, seen as mip.MTIP
  input  wire logic                            timer_pending_i,
  // To fetch
  output      logic [riscv_csr_pkg::xlen-1:0]  mtvec_o,
  output      logic [riscv_csr_pkg::xlen-1:0]  mepc_o,
  // Trap strobes and enables
  trap_if.csr                                  trap
);

  localparam int XL = riscv_csr_pkg::xlen;

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  logic [XL-1:0] mstatus_q;     // Only MIE / MPIE ever set
  logic [XL-1:0] mie_q;         // Only MTIE ever set
  logic [XL-1:0] mtvec_q;
  logic [XL-1:0] mscratch_q;
  logic [XL-1:0] mepc_q;
  logic [XL-1:0] mcause_q;
  logic [XL-1:0] mtval_q;

  logic [XL-1:0] mstatus_rd;    // With MPP forced
  logic [XL-1:0] mip_rd;        // Built from timer level
  logic [XL-1:0] wval;          // Value before per-register masking
  logic          we;

  ////////////////////////////////////////
  // Read side
  ////////////////////////////////////////

  always_comb begin
    mstatus_rd = mstatus_q;
    mstatus_rd[riscv_csr_pkg::MSTATUS_MPP_MSB:riscv_csr_pkg::MSTATUS_MPP_LSB] =
      riscv_csr_pkg::MSTATUS_MPP;                            // M-mode only
    mip_rd = '0;
    mip_rd[riscv_csr_pkg::MTIP_BIT] = timer_pending_i;      // Read-only level
  end

  always_comb begin
    case (csr_addr_i)
      riscv_csr_pkg::CSR_MSTATUS:  csr_rdata_o = mstatus_rd;
      riscv_csr_pkg::CSR_MIE:      csr_rdata_o = mie_q;
      riscv_csr_pkg::CSR_MTVEC:    csr_rdata_o = mtvec_q;
      riscv_csr_pkg::CSR_MSCRATCH: csr_rdata_o = mscratch_q;
      riscv_csr_pkg::CSR_MEPC:     csr_rdata_o = mepc_q;
      riscv_csr_pkg::CSR_MCAUSE:   csr_rdata_o = mcause_q;
      riscv_csr_pkg::CSR_MTVAL:    csr_rdata_o = mtval_q;
      riscv_csr_pkg::CSR_MIP:      csr_rdata_o = mip_rd;
      default:                     csr_rdata_o = '0;        // Unknown address
    endcase
  end

  ////////////////////////////////////////
  // Operation decode
  ////////////////////////////////////////

  always_comb begin
    we = 1'b1;
    case (csr_op_i)
      riscv_csr_pkg::CSR_RW: wval = csr_wdata_i;
      riscv_csr_pkg::CSR_RS: wval = csr_rdata_o | csr_wdata_i;     // Set bits
      riscv_csr_pkg::CSR_RC: wval = csr_rdata_o & ~csr_wdata_i;    // Clear bits
      default: begin
        wval = csr_rdata_o;
        we   = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////
  // Update
  ////////////////////////////////////////

  // Later assignments win: CSR write, then mret, then trap
  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q  <= '0;
      mie_q      <= '0;
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
    end else begin
      if (we) begin
        case (csr_addr_i)
          riscv_csr_pkg::CSR_MSTATUS:  mstatus_q  <= wval & riscv_csr_pkg::MSTATUS_WMASK;
          riscv_csr_pkg::CSR_MIE:      mie_q      <= wval & riscv_csr_pkg::MIE_WMASK;
          riscv_csr_pkg::CSR_MTVEC:    mtvec_q    <= {wval[XL-1:2], 2'b00};  // Direct mode
          riscv_csr_pkg::CSR_MSCRATCH: mscratch_q <= wval;
          riscv_csr_pkg::CSR_MEPC:     mepc_q     <= {wval[XL-1:2], 2'b00};
          riscv_csr_pkg::CSR_MCAUSE:   mcause_q   <= wval;
          riscv_csr_pkg::CSR_MTVAL:    mtval_q    <= wval;
          default: ;                                        // mip, unknown
        endcase
      end
      if (trap.mret) begin
        mstatus_q[riscv_csr_pkg::MSTATUS_MIE_BIT]  <=
          mstatus_q[riscv_csr_pkg::MSTATUS_MPIE_BIT];        // Restore enable
        mstatus_q[riscv_csr_pkg::MSTATUS_MPIE_BIT] <= 1'b1;
      end
      if (trap.take) begin
        mepc_q   <= trap.epc;
        mcause_q <= trap.cause;
        mtval_q  <= trap.tval;
        // Stack the global enable
        mstatus_q[riscv_csr_pkg::MSTATUS_MPIE_BIT] <=
          mstatus_q[riscv_csr_pkg::MSTATUS_MIE_BIT];
        mstatus_q[riscv_csr_pkg::MSTATUS_MIE_BIT]  <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

  assign trap.global_ie = mstatus_q[riscv_csr_pkg::MSTATUS_MIE_BIT];
  assign trap.mtie      = mie_q[riscv_csr_pkg::MTIE_BIT];

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Holds across writes, traps and returns alike
  a_mstatus_mask: assert property (
    @(posedge clk) disable iff (rst)
    (mstatus_q & ~riscv_csr_pkg::MSTATUS_WMASK) == '0
  ) else $error("mstatus holds bits outside its write mask");

endmodule

`default_nettype wire

//--- csr_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module csr_subsystem (
  input  wire logic                            clk,
  input  wire logic                            rst,
  // CSR instruction
  input  wire riscv_csr_pkg::csr_op_t          csr_op_i,
  input  wire riscv_csr_pkg::csr_addr_t        csr_addr_i,
  input  wire logic [riscv_csr_pkg::xlen-1:0]  csr_wdata_i,
  output      logic [riscv_csr_pkg::xlen-1:0]  csr_rdata_o,
  // Pipeline exception and return
  input  wire logic                            exc_req_i,
  input  wire logic [riscv_csr_pkg::xlen-1:0]  exc_cause_i,
  input  wire logic [riscv_csr_pkg::xlen-1:0]  tval_i,
  input  wire logic [riscv_csr_pkg::xlen-1:0]  pc_i,
  input  wire logic                            mret_i,
  output      logic                            trap_o,
  output      logic [riscv_csr_pkg::xlen-1:0]  mtvec_o,     // Trap vector
  output      logic [riscv_csr_pkg::xlen-1:0]  mepc_o,
  // Memory-mapped timer
  input  wire logic                            tmr_we_i,
  input  wire riscv_csr_pkg::timer_addr_t      tmr_addr_i,
  input  wire logic [riscv_csr_pkg::xlen-1:0]  tmr_wdata_i,
  output      logic [riscv_csr_pkg::xlen-1:0]  tmr_rdata_o
);

  logic   timer_pending;   // mtime >= mtimecmp
  trap_if trap_bus ();

  machine_timer u_timer (
    .clk             (clk),
    .rst             (rst),
    .tmr_we_i        (tmr_we_i),
    .tmr_addr_i      (tmr_addr_i),
    .tmr_wdata_i     (tmr_wdata_i),
    .tmr_rdata_o     (tmr_rdata_o),
    .timer_pending_o (timer_pending)
  );

  trap_ctrl u_trap_ctrl (
    .exc_req_i       (exc_req_i),
    .exc_cause_i     (exc_cause_i),
    .tval_i          (tval_i),
    .pc_i            (pc_i),
    .mret_i          (mret_i),
    .timer_pending_i (timer_pending),
    .trap            (trap_bus.ctrl)
  );

  csr_file u_csr_file (
    .clk             (clk),
    .rst             (rst),
    .csr_op_i        (csr_op_i),
    .csr_addr_i      (csr_addr_i),
    .csr_wdata_i     (csr_wdata_i),
    .csr_rdata_o     (csr_rdata_o),
    .timer_pending_i (timer_pending),
    .mtvec_o         (mtvec_o),
    .mepc_o          (mepc_o),
    .trap            (trap_bus.csr)
  );

  assign trap_o = trap_bus.take;   // Same cycle as the request

endmodule

`default_nettype wire

//--- csr_tb.sv
`timescale 1ns/100ps
`default_nettype none

module csr_tb;

  localparam int num_cycles = 3000;
  localparam int period_ns  = 10;
  localparam int timeout_ns = (num_cycles + 5 + 200) * period_ns;   // Reset, drain, margin

  logic                         clk;
  logic                         rst;
  riscv_csr_pkg::csr_op_t       csr_op;
  riscv_csr_pkg::csr_addr_t     csr_addr;
  logic [31:0]                  csr_wdata;
  logic [31:0]                  csr_rdata;
  logic                         exc_req;
  logic [31:0]                  exc_cause;
  logic [31:0]                  tval;
  logic [31:0]                  pc;
  logic                         mret;
  logic                         trap;
  logic [31:0]                  mtvec;        // Trap vector
  logic [31:0]                  mepc;
  logic                         tmr_we;
  riscv_csr_pkg::timer_addr_t   tmr_addr;
  logic [31:0]                  tmr_wdata;
  logic [31:0]                  tmr_rdata;
  int                           seed;
  int                           errors;
  int                           checks;

  tb_clk_gen u_clk_gen (.clk_o(clk), .rst_o(rst));

  csr_subsystem u_dut (
    .clk (clk), .rst (rst),
    .csr_op_i (csr_op), .csr_addr_i (csr_addr), .csr_wdata_i (csr_wdata),
    .csr_rdata_o (csr_rdata),
    .exc_req_i (exc_req), .exc_cause_i (exc_cause), .tval_i (tval), .pc_i (pc),
    .mret_i (mret), .trap_o (trap), .mtvec_o (mtvec), .mepc_o (mepc),
    .tmr_we_i (tmr_we), .tmr_addr_i (tmr_addr), .tmr_wdata_i (tmr_wdata),
    .tmr_rdata_o (tmr_rdata)
  );

  csr_checker u_checker (
    .clk_i (clk), .rst_i (rst),
    .csr_op_i (csr_op), .csr_addr_i (csr_addr), .csr_wdata_i (csr_wdata),
    .exc_req_i (exc_req), .exc_cause_i (exc_cause), .tval_i (tval), .pc_i (pc),
    .mret_i (mret), .tmr_we_i (tmr_we), .tmr_addr_i (tmr_addr), .tmr_wdata_i (tmr_wdata),
    .csr_rdata_i (csr_rdata), .trap_i (trap), .trap_pc_i (mtvec), .mepc_i (mepc),
    .tmr_rdata_i (tmr_rdata),
    .err_count_o (errors), .check_count_o (checks)
  );

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // Implemented CSRs plus one unmapped number
  function automatic riscv_csr_pkg::csr_addr_t pick_addr(input int n);
    case (n)
      0:       pick_addr = riscv_csr_pkg::CSR_MSTATUS;
      1:       pick_addr = riscv_csr_pkg::CSR_MIE;
      2:       pick_addr = riscv_csr_pkg::CSR_MTVEC;
      3:       pick_addr = riscv_csr_pkg::CSR_MSCRATCH;
      4:       pick_addr = riscv_csr_pkg::CSR_MEPC;
      5:       pick_addr = riscv_csr_pkg::CSR_MCAUSE;
      6:       pick_addr = riscv_csr_pkg::CSR_MTVAL;
      7:       pick_addr = riscv_csr_pkg::CSR_MIP;
      default: pick_addr = 12'h7c0;              // Not implemented
    endcase
  endfunction

  task automatic set_idle();
    csr_op    = riscv_csr_pkg::CSR_NOP;
    csr_addr  = '0;
    csr_wdata = '0;
    exc_req   = 1'b0;
    exc_cause = '0;
    tval      = '0;
    pc        = '0;
    mret      = 1'b0;
    tmr_we    = 1'b0;
    tmr_addr  = '0;
    tmr_wdata = '0;
  endtask

  task automatic drive_random();
    logic [31:0] r;
    r         = $random(seed);
    csr_op    = riscv_csr_pkg::csr_op_t'(r[1:0]);
    csr_addr  = pick_addr($unsigned($random(seed)) % 9);
    csr_wdata = $random(seed);
    exc_req   = (r[4:2] == 3'd0);                  // About 1 in 8
    exc_cause = {28'd0, r[8:5]};
    tval      = $random(seed);
    pc        = $random(seed);                     // Low bits left random on purpose
    mret      = (r[12:9] == 4'd0);                 // About 1 in 16
    tmr_we    = (r[16:13] == 4'd0);
    tmr_addr  = r[18:17];
    if (r[17]) begin
      tmr_wdata = {31'd0, r[19]};                  // Upper words stay 0 or 1
    end else begin
      tmr_wdata = $random(seed) & 32'h0000_0fff;   // Near the running count
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    seed = 56;
    set_idle();
    wait (rst == 1'b0);
    repeat (num_cycles) begin
      @(negedge clk);
      drive_random();
    end
    @(negedge clk);
    set_idle();
    repeat (2) @(negedge clk);                     // Let the last compares land
    $display("Closing: %0d errors in %0d checks", errors, checks);
    if (errors == 0 && checks > 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(timeout_ns);
    $display("Timeout: run did not finish within %0d ns", timeout_ns);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- machine_timer.sv
`timescale 1ns/100ps
`default_nettype none

module machine_timer (
  input  wire logic                            clk,
  input  wire logic                            rst,
  // Word bus
  input  wire logic                            tmr_we_i,
  input  wire riscv_csr_pkg::timer_addr_t      tmr_addr_i,
  input  wire logic [riscv_csr_pkg::xlen-1:0]  tmr_wdata_i,
  output      logic [riscv_csr_pkg::xlen-1:0]  tmr_rdata_o,
  // Level to trap logic and mip
  output      logic                            timer_pending_o
);

  localparam int XL = riscv_csr_pkg::xlen;

  logic [riscv_csr_pkg::time_w-1:0] mtime_q;
  logic [riscv_csr_pkg::time_w-1:0] mtimecmp_q;
  logic                             mtime_wr;     // This edge rewrites a half of mtime

  assign mtime_wr = tmr_we_i &&
                    ((tmr_addr_i == riscv_csr_pkg::MTIME_LO) ||
                     (tmr_addr_i == riscv_csr_pkg::MTIME_HI));

  ////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////

  always_comb begin
    case (tmr_addr_i)
      riscv_csr_pkg::MTIME_LO:    tmr_rdata_o = mtime_q[XL-1:0];
      riscv_csr_pkg::MTIME_HI:    tmr_rdata_o = mtime_q[2*XL-1:XL];
      riscv_csr_pkg::MTIMECMP_LO: tmr_rdata_o = mtimecmp_q[XL-1:0];
      default:                    tmr_rdata_o = mtimecmp_q[2*XL-1:XL];
    endcase
  end

  ////////////////////////////////////////
  // Counter and compare registers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q    <= '0;
      mtimecmp_q <= '0;
    end else begin
      if (!mtime_wr) begin
        mtime_q <= mtime_q + 1'b1;                           // Free running
      end
      if (tmr_we_i) begin
        case (tmr_addr_i)
          riscv_csr_pkg::MTIME_LO: begin
            mtime_q <= {mtime_q[2*XL-1:XL], tmr_wdata_i};      // Upper half held
          end
          riscv_csr_pkg::MTIME_HI: begin
            mtime_q <= {tmr_wdata_i, mtime_q[XL-1:0]};         // Lower half held
          end
          riscv_csr_pkg::MTIMECMP_LO: begin
            mtimecmp_q <= {mtimecmp_q[2*XL-1:XL], tmr_wdata_i};
          end
          default: begin
            mtimecmp_q <= {tmr_wdata_i, mtimecmp_q[XL-1:0]};
          end
        endcase
      end
    end
  end

  // Unsigned 64-bit compare of the registered values
  assign timer_pending_o = (mtime_q >= mtimecmp_q);

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Counter never stalls or skips when left alone
  a_mtime_advances: assert property (
    @(posedge clk) disable iff (rst)
    !mtime_wr |=> (mtime_q == $past(mtime_q) + 1'b1)
  ) else $error("mtime did not advance by one");

endmodule

`default_nettype wire

//--- riscv_csr_pkg.sv
`default_nettype none

package riscv_csr_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int xlen   = 32;          // Register width
  localparam int time_w = 2 * xlen;    // mtime / mtimecmp width

  ////////////////////////////////////////
  // CSR instruction side
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    CSR_NOP = 2'b00,                   // No write
    CSR_RW  = 2'b01,                   // Read-write
    CSR_RS  = 2'b10,                   // Read-set
    CSR_RC  = 2'b11                    // Read-clear
  } csr_op_t;

  typedef logic [11:0] csr_addr_t;

  // Machine CSR numbers
  localparam csr_addr_t CSR_MSTATUS  = 12'h300;
  localparam csr_addr_t CSR_MIE      = 12'h304;
  localparam csr_addr_t CSR_MTVEC    = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MEPC     = 12'h341;
  localparam csr_addr_t CSR_MCAUSE   = 12'h342;
  localparam csr_addr_t CSR_MTVAL    = 12'h343;
  localparam csr_addr_t CSR_MIP      = 12'h344;

  ////////////////////////////////////////
  // Timer bus
  ////////////////////////////////////////

  typedef logic [1:0] timer_addr_t;    // Word offset

  localparam timer_addr_t MTIME_LO    = 2'd0;
  localparam timer_addr_t MTIME_HI    = 2'd1;
  localparam timer_addr_t MTIMECMP_LO = 2'd2;
  localparam timer_addr_t MTIMECMP_HI = 2'd3;

  ////////////////////////////////////////
  // Bit positions, masks, causes
  ////////////////////////////////////////

  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LSB  = 11;
  localparam int MSTATUS_MPP_MSB  = 12;
  localparam logic [1:0] MSTATUS_MPP = 2'b11;   // Machine mode only

  localparam int MTIE_BIT = 7;         // mie
  localparam int MTIP_BIT = 7;         // mip

  // Writable bits per register
  localparam logic [xlen-1:0] MSTATUS_WMASK = 32'h0000_0088;   // MPIE, MIE
  localparam logic [xlen-1:0] MIE_WMASK     = 32'h0000_0080;   // MTIE

  localparam logic [xlen-1:0] CAUSE_M_TIMER = 32'h8000_0007;

endpackage

`default_nettype wire

//--- src.f
riscv_csr_pkg.sv
trap_if.sv
machine_timer.sv
trap_ctrl.sv
csr_file.sv
csr_subsystem.sv
tb_clk_gen.sv
csr_checker.sv
csr_tb.sv

//--- tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  localparam int half_period = 5;   // 10 ns clock

  initial begin
    clk_o = 1'b0;
    forever #(half_period) clk_o = ~clk_o;
  end

  // Held for 5 rising edges, released between edges
  initial begin
    rst_o = 1'b1;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- trap_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module trap_ctrl (
  // From the pipeline
  input  wire logic                            exc_req_i,     // Synchronous exception
  input  wire logic [riscv_csr_pkg::xlen-1:0]  exc_cause_i,
  input  wire logic [riscv_csr_pkg::xlen-1:0]  tval_i,
  input  wire logic [riscv_csr_pkg::xlen-1:0]  pc_i,
  input  wire logic                            mret_i,
  // From the timer
  input  wire logic                            timer_pending_i,
  // To and from the CSR file
  trap_if.ctrl                                 trap
);

  logic timer_irq;   // Enabled timer interrupt
  logic exc_take;    // Enabled exception

  ////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////

  // Both sources gated by mstatus.MIE, timer also by mie.MTIE
  assign timer_irq = trap.global_ie && trap.mtie && timer_pending_i;
  assign exc_take  = trap.global_ie && exc_req_i;

  assign trap.take = timer_irq || exc_take;

  // Timer has priority, exception request dropped
  always_comb begin
    if (timer_irq) begin
      trap.cause = riscv_csr_pkg::CAUSE_M_TIMER;
      trap.tval  = '0;                               // No trap value for interrupts
    end else begin
      trap.cause = exc_cause_i;
      trap.tval  = tval_i;
    end
  end

  // Saved pc, word aligned
  assign trap.epc = {pc_i[riscv_csr_pkg::xlen-1:2], 2'b00};

  ////////////////////////////////////////
  // Trap return
  ////////////////////////////////////////

  // A trap in the same cycle wins over mret
  assign trap.mret = mret_i && !trap.take;

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Pipeline exceptions are synchronous, interrupt bit never set
  always_comb begin
    a_exc_cause_sync: assert (!(exc_req_i && exc_cause_i[riscv_csr_pkg::xlen-1]))
      else $error("exception request carries an interrupt cause");
  end

endmodule

`default_nettype wire

//--- trap_if.sv
`timescale 1ns/100ps
`default_nettype none

interface trap_if;

  // Controller to CSR file
  logic                             take;       // One-cycle trap strobe
  logic                             mret;       // Trap return strobe
  logic [riscv_csr_pkg::xlen-1:0]   cause;
  logic [riscv_csr_pkg::xlen-1:0]   epc;        // Word aligned
  logic [riscv_csr_pkg::xlen-1:0]   tval;

  // CSR file to controller
  logic                             global_ie;  // mstatus.MIE
  logic                             mtie;       // mie.MTIE

  modport ctrl (
    output take, mret, cause, epc, tval,
    input  global_ie, mtie
  );

  modport csr (
    input  take, mret, cause, epc, tval,
    output global_ie, mtie
  );

endinterface

`default_nettype wire
